//--- csr_unit.f
logic/csr_pkg.sv
logic/csr_access.sv
logic/machine_csrs.sv
logic/perf_counters.sv
logic/csr_unit_top.sv
tb/csr_unit_tb.sv

//--- Makefile
.PHONY: sim clean

LOG = sim.log

sim:
	verilator --binary --assert --timing --top-module csr_unit_tb -f csr_unit.f
	-./obj_dir/Vcsr_unit_tb > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/csr_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit_tb import csr_pkg::*; ();

  localparam logic [31:0] BOOT_ADDR  = 32'h1c00_8000;
  localparam logic [3:0]  CORE_ID    = 4'h5;
  localparam logic [5:0]  CLUSTER_ID = 6'h2a;
  localparam logic [11:0] PCCR_CYCLE = 12'h780;  // window base + EV_CYCLE
  localparam logic [11:0] PCCR_LOAD  = 12'h783;  // window base + EV_LOAD
  localparam logic [11:0] PCCR_NONE  = 12'h78c;  // index 12 has no counter

  logic        clk_i;
  logic        rst_ni;
  logic        csr_access_i;
  csr_num_e    csr_addr_i;
  logic [31:0] csr_wdata_i;
  csr_op_e     csr_op_i;
  logic [31:0] csr_rdata_o;
  logic [31:0] pc_if_i;
  logic [31:0] pc_id_i;
  logic        csr_save_if_i;
  logic        csr_save_id_i;
  logic        csr_save_cause_i;
  logic [5:0]  csr_cause_i;
  logic        csr_restore_mret_i;
  logic        m_irq_enable_o;
  logic [31:0] mepc_o;
  logic        mem_load_i;

  integer      seed;
  int unsigned load_count;  // loads seen by the testbench
  logic        load_bit;
  logic [31:0] rd;
  logic [31:0] mask;
  logic [31:0] model;
  logic [31:0] trap_pc;
  logic        mie;
  logic        mpie;

  csr_unit_top #(.RV32E(1'b0), .RV32M(1'b1)) u_dut (
    .clk_i, .rst_ni, .boot_addr_i(BOOT_ADDR), .core_id_i(CORE_ID),
    .cluster_id_i(CLUSTER_ID), .csr_access_i, .csr_addr_i, .csr_wdata_i,
    .csr_op_i, .csr_rdata_o, .pc_if_i, .pc_id_i, .csr_save_if_i, .csr_save_id_i,
    .csr_save_cause_i, .csr_cause_i, .csr_restore_mret_i, .m_irq_enable_o, .mepc_o,
    .if_valid_i(1'b0), .id_valid_i(1'b0), .is_compressed_i(1'b0), .is_decoding_i(1'b0),
    .imiss_i(1'b0), .pc_set_i(1'b0), .jump_i(1'b0), .branch_i(1'b0),
    .branch_taken_i(1'b0), .mem_load_i, .mem_store_i(1'b0)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else stop_with_error($sformatf("mismatch %s: expected 0x%08h, got 0x%08h", name, exp, act));
  endtask

  // architectural mstatus with mpp pinned to machine
  function automatic logic [31:0] mstatus_view(input logic ie, input logic pie);
    return 32'h0000_1800 | (32'(pie) << 7) | (32'(ie) << 3);
  endfunction

  task automatic csr_write(input logic [11:0] addr, input csr_op_e op, input logic [31:0] data);
    @(negedge clk_i);
    csr_access_i = 1'b1;
    csr_addr_i   = csr_num_e'(addr);
    csr_op_i     = op;
    csr_wdata_i  = data;
    @(negedge clk_i);  // committed at the rising edge in between
    csr_access_i = 1'b0;
    csr_op_i     = CSR_OP_NONE;
  endtask

  task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
    @(negedge clk_i);
    csr_access_i = 1'b1;  // counters only answer a real access
    csr_op_i     = CSR_OP_NONE;
    csr_addr_i   = csr_num_e'(addr);
    #1;
    data = csr_rdata_o;
  endtask

  task automatic csr_read_check(input logic [11:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] val;
    csr_read(addr, val);
    check_value(name, exp, val);
  endtask

  task automatic trap_pulse(input logic from_if, input logic [5:0] cause, input logic [31:0] pc);
    @(negedge clk_i);
    csr_save_cause_i = 1'b1;
    csr_save_if_i    = from_if;
    csr_save_id_i    = !from_if;
    csr_cause_i      = cause;
    pc_if_i          = from_if ? pc : ~pc;  // other stage holds a decoy
    pc_id_i          = from_if ? ~pc : pc;
    @(negedge clk_i);
    csr_save_cause_i = 1'b0;
    csr_save_if_i    = 1'b0;
    csr_save_id_i    = 1'b0;
  endtask

  task automatic mret_pulse();
    @(negedge clk_i);
    csr_restore_mret_i = 1'b1;
    @(negedge clk_i);
    csr_restore_mret_i = 1'b0;
  endtask

  task automatic wait_irq_enable(input logic expected, input int max_cycles);
    int cycles;
    cycles = 0;
    while (m_irq_enable_o !== expected) begin
      if (cycles >= max_cycles) stop_with_error("timeout waiting for m_irq_enable_o to change");
      @(negedge clk_i);
      cycles++;
    end
  endtask

  task automatic trap_and_return(input logic from_if);
    logic [5:0]  cause;
    logic [31:0] pc;
    cause = 6'($random(seed));
    pc    = $random(seed);
    csr_write(CSR_MSTATUS, CSR_OP_WRITE, 32'h8);  // mie on with mpie cleared
    trap_pulse(from_if, cause, pc);
    #1;
    check_value("mepc_o", pc, mepc_o);
    csr_read_check(CSR_MCAUSE, (32'(cause[5]) << 31) | 32'(cause[4:0]), "mcause");
    csr_read_check(CSR_MSTATUS, mstatus_view(1'b0, 1'b1), "mstatus after trap");
    check_value("m_irq_enable_o", 32'h0, {31'b0, m_irq_enable_o});
    mret_pulse();
    wait_irq_enable(1'b1, 4);
    csr_read_check(CSR_MSTATUS, mstatus_view(1'b1, 1'b1), "mstatus after mret");
  endtask

  // watchdog
  initial begin
    repeat (3000) @(posedge clk_i);
    stop_with_error("watchdog expired before the test sequence finished");
  end

  ////////////////////////////////////////
  // sequence
  ////////////////////////////////////////

  initial begin
    seed = 32'ha836_3eec;
    rst_ni = 1'b0;
    csr_access_i = 1'b0;
    csr_addr_i = CSR_MSTATUS;
    csr_wdata_i = '0;
    csr_op_i = CSR_OP_NONE;
    pc_if_i = '0;
    pc_id_i = '0;
    csr_save_if_i = 1'b0;
    csr_save_id_i = 1'b0;
    csr_save_cause_i = 1'b0;
    csr_cause_i = '0;
    csr_restore_mret_i = 1'b0;
    mem_load_i = 1'b0;
    load_count = 0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    // reset view
    csr_read_check(CSR_MSTATUS, 32'h0000_1800, "mstatus");
    check_value("m_irq_enable_o", 32'h0, {31'b0, m_irq_enable_o});
    csr_read_check(CSR_MISA, 32'h4000_1104, "misa");
    csr_read_check(CSR_MHARTID, (32'(CLUSTER_ID) << 5) | 32'(CORE_ID), "mhartid");
    csr_read_check(CSR_MTVEC, BOOT_ADDR, "mtvec");
    csr_read_check(CSR_PCMR, 32'h3, "pcmr");
    csr_read_check(CSR_PCER, 32'h0, "pcer");

    // write, set, clear on mepc
    model = $random(seed);
    csr_write(CSR_MEPC, CSR_OP_WRITE, model);
    csr_read_check(CSR_MEPC, model, "mepc write");
    mask = $random(seed);
    csr_write(CSR_MEPC, CSR_OP_SET, mask);
    model = model | mask;
    csr_read_check(CSR_MEPC, model, "mepc set");
    mask = $random(seed);
    csr_write(CSR_MEPC, CSR_OP_CLEAR, mask);
    model = model & ~mask;
    csr_read_check(CSR_MEPC, model, "mepc clear");

    // same on mstatus where only the two enables move
    mask = $random(seed);
    csr_write(CSR_MSTATUS, CSR_OP_SET, mask);
    mie  = mask[3];
    mpie = mask[7];
    csr_read_check(CSR_MSTATUS, mstatus_view(mie, mpie), "mstatus set");
    mask = $random(seed);
    csr_write(CSR_MSTATUS, CSR_OP_CLEAR, mask);
    mie  = mie & ~mask[3];
    mpie = mpie & ~mask[7];
    csr_read_check(CSR_MSTATUS, mstatus_view(mie, mpie), "mstatus clear");

    trap_and_return(1'b1);  // pc from IF
    trap_and_return(1'b0);  // pc from ID

    // trap against a software mepc write in one cycle
    trap_pc = $random(seed);
    @(negedge clk_i);
    csr_access_i = 1'b1;
    csr_addr_i = CSR_MEPC;
    csr_op_i = CSR_OP_WRITE;
    csr_wdata_i = ~trap_pc;
    csr_save_cause_i = 1'b1;
    csr_save_id_i = 1'b1;
    pc_id_i = trap_pc;
    @(negedge clk_i);
    csr_access_i = 1'b0;
    csr_op_i = CSR_OP_NONE;
    csr_save_cause_i = 1'b0;
    csr_save_id_i = 1'b0;
    #1;
    check_value("mepc_o", trap_pc, mepc_o);

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////

    csr_write(CSR_PCER, CSR_OP_WRITE, 32'h9);    // cycle + load
    csr_write(CSR_PCCR31, CSR_OP_WRITE, 32'h0);  // clear all
    for (int i = 0; i < 50; i++) begin
      @(negedge clk_i);
      csr_access_i = 1'b0;
      load_bit = 1'($random(seed));
      mem_load_i = load_bit;
      if (load_bit) load_count++;
    end
    @(negedge clk_i);
    mem_load_i = 1'b0;
    csr_write(CSR_PCER, CSR_OP_WRITE, 32'h0);
    repeat (3) @(negedge clk_i);
    csr_read_check(PCCR_LOAD, load_count, "load counter");
    csr_read(PCCR_CYCLE, rd);
    assert (rd >= 32'd50)
      else stop_with_error($sformatf("mismatch cycle counter: expected >= 0x32, got 0x%08h", rd));
    csr_read_check(PCCR_NONE, 32'h0, "counter index 12");

    // saturate and then wrap
    csr_write(CSR_PCMR, CSR_OP_WRITE, 32'h3);
    csr_write(PCCR_CYCLE, CSR_OP_WRITE, 32'hffff_ffff);
    csr_write(CSR_PCER, CSR_OP_WRITE, 32'h1);
    repeat (5) @(negedge clk_i);
    csr_read_check(PCCR_CYCLE, 32'hffff_ffff, "saturated cycle counter");
    csr_write(CSR_PCER, CSR_OP_WRITE, 32'h0);
    csr_write(CSR_PCMR, CSR_OP_WRITE, 32'h1);    // enable without saturate
    csr_write(PCCR_CYCLE, CSR_OP_WRITE, 32'hffff_fffe);
    csr_write(CSR_PCER, CSR_OP_WRITE, 32'h1);
    repeat (4) @(negedge clk_i);
    csr_write(CSR_PCER, CSR_OP_WRITE, 32'h0);
    repeat (3) @(negedge clk_i);
    csr_read(PCCR_CYCLE, rd);
    assert (rd < 32'h10)
      else stop_with_error(
        $sformatf("mismatch wrapped cycle counter: expected < 0x10, got 0x%08h", rd));

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/csr_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit_top import csr_pkg::*; #(
  parameter bit RV32E = 1'b0,
  parameter bit RV32M = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_ni,

  // static configuration
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic [3:0]      core_id_i,
  input  logic [5:0]      cluster_id_i,

  // register port
  input  logic            csr_access_i,
  input  csr_num_e        csr_addr_i,
  input  logic [XLEN-1:0] csr_wdata_i,
  input  csr_op_e         csr_op_i,
  output logic [XLEN-1:0] csr_rdata_o,

  // traps
  input  logic [XLEN-1:0] pc_if_i,
  input  logic [XLEN-1:0] pc_id_i,
  input  logic            csr_save_if_i,
  input  logic            csr_save_id_i,
  input  logic            csr_save_cause_i,
  input  logic [5:0]      csr_cause_i,
  input  logic            csr_restore_mret_i,
  output logic            m_irq_enable_o,
  output logic [XLEN-1:0] mepc_o,

  // performance events
  input  logic            if_valid_i,
  input  logic            id_valid_i,
  input  logic            is_compressed_i,
  input  logic            is_decoding_i,
  input  logic            imiss_i,
  input  logic            pc_set_i,
  input  logic            jump_i,
  input  logic            branch_i,
  input  logic            branch_taken_i,
  input  logic            mem_load_i,
  input  logic            mem_store_i
);

  logic [XLEN-1:0] machine_rdata;
  logic [XLEN-1:0] perf_rdata;
  logic            perf_hit;
  logic [XLEN-1:0] csr_wdata;  // after set/clear merge
  logic            csr_we;

  csr_access u_access (
    .csr_access_i    (csr_access_i),
    .csr_op_i        (csr_op_i),
    .csr_wdata_i     (csr_wdata_i),
    .machine_rdata_i (machine_rdata),
    .perf_rdata_i    (perf_rdata),
    .perf_hit_i      (perf_hit),
    .csr_rdata_o     (csr_rdata_o),
    .csr_wdata_o     (csr_wdata),
    .csr_we_o        (csr_we)
  );

  machine_csrs #(
    .RV32E (RV32E),
    .RV32M (RV32M)
  ) u_machine (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_addr_i         (csr_addr_i),
    .csr_wdata_i        (csr_wdata),
    .csr_we_i           (csr_we),
    .boot_addr_i        (boot_addr_i),
    .core_id_i          (core_id_i),
    .cluster_id_i       (cluster_id_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_cause_i        (csr_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_rdata_o        (machine_rdata),
    .m_irq_enable_o     (m_irq_enable_o),
    .mepc_o             (mepc_o)
  );

  perf_counters u_perf (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .csr_access_i    (csr_access_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wdata_i     (csr_wdata),
    .csr_we_i        (csr_we),
    .if_valid_i      (if_valid_i),
    .id_valid_i      (id_valid_i),
    .is_compressed_i (is_compressed_i),
    .is_decoding_i   (is_decoding_i),
    .imiss_i         (imiss_i),
    .pc_set_i        (pc_set_i),
    .jump_i          (jump_i),
    .branch_i        (branch_i),
    .branch_taken_i  (branch_taken_i),
    .mem_load_i      (mem_load_i),
    .mem_store_i     (mem_store_i),
    .perf_rdata_o    (perf_rdata),
    .perf_hit_o      (perf_hit)
  );

endmodule

`default_nettype wire

//--- logic/perf_counters.sv
`timescale 1ns/1ns
`default_nettype none

module perf_counters import csr_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,

  // register port
  input  logic            csr_access_i,
  input  csr_num_e        csr_addr_i,
  input  logic [XLEN-1:0] csr_wdata_i,
  input  logic            csr_we_i,

  // event levels from the pipeline
  input  logic            if_valid_i,      // new instr out of IF
  input  logic            id_valid_i,      // ID done
  input  logic            is_compressed_i,
  input  logic            is_decoding_i,   // controller in decode
  input  logic            imiss_i,         // fetch stall
  input  logic            pc_set_i,        // pc redirected
  input  logic            jump_i,
  input  logic            branch_i,
  input  logic            branch_taken_i,
  input  logic            mem_load_i,
  input  logic            mem_store_i,

  output logic [XLEN-1:0] perf_rdata_o,
  output logic            perf_hit_o
);

  localparam int unsigned PCMR_EN  = 0;  // global enable
  localparam int unsigned PCMR_SAT = 1;  // stick at all ones

  logic [11:0]                  csr_addr;
  logic                         is_pcer;
  logic                         is_pcmr;
  logic                         is_pccr;
  logic                         pccr_all_sel;
  logic [4:0]                   pccr_index;

  logic [NUM_PERF_COUNTERS-1:0] pccr_in;     // raw events
  logic [NUM_PERF_COUNTERS-1:0] pccr_inc;    // masked events
  logic [NUM_PERF_COUNTERS-1:0] pccr_inc_q;  // one cycle later
  logic [NUM_PERF_COUNTERS-1:0][XLEN-1:0] pccr_q, pccr_n;
  logic [NUM_PERF_COUNTERS-1:0] pcer_q, pcer_n;
  logic [1:0]                   pcmr_q, pcmr_n;

  ////////////////////////////////////////
  // event inputs
  ////////////////////////////////////////

  assign pccr_in[EV_CYCLE]        = 1'b1;
  assign pccr_in[EV_INSTR]        = if_valid_i;
  assign pccr_in[EV_IMISS]        = imiss_i & ~pc_set_i; // jumps not counted as misses
  assign pccr_in[EV_LOAD]         = mem_load_i;
  assign pccr_in[EV_STORE]        = mem_store_i;
  assign pccr_in[EV_JUMP]         = jump_i;
  assign pccr_in[EV_BRANCH]       = branch_i;
  assign pccr_in[EV_BRANCH_TAKEN] = branch_taken_i;
  assign pccr_in[EV_COMPRESSED]   = id_valid_i & is_decoding_i & is_compressed_i;

  assign pccr_inc = pccr_in & pcer_q & {NUM_PERF_COUNTERS{pcmr_q[PCMR_EN]}};

  ////////////////////////////////////////
  // address decode and read
  ////////////////////////////////////////

  assign csr_addr     = csr_addr_i;
  assign is_pcer      = (csr_addr_i == CSR_PCER);
  assign is_pcmr      = (csr_addr_i == CSR_PCMR);
  assign is_pccr      = (csr_addr[11:5] == PCCR_BASE_UPPER); // 0x780..0x79F
  assign pccr_all_sel = (csr_addr_i == CSR_PCCR31);
  assign pccr_index   = csr_addr[4:0];

  assign perf_hit_o = csr_access_i & (is_pcer | is_pcmr | is_pccr);

  always_comb begin
    perf_rdata_o = '0;
    if (is_pcer) begin
      perf_rdata_o = XLEN'(pcer_q);
    end else if (is_pcmr) begin
      perf_rdata_o = XLEN'(pcmr_q);
    end else if (is_pccr) begin
      // slots past the last counter stay zero
      for (int c = 0; c < NUM_PERF_COUNTERS; c++) begin
        if (pccr_index == 5'(c)) begin
          perf_rdata_o = pccr_q[c];
        end
      end
    end
  end

  ////////////////////////////////////////
  // counter update
  ////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < NUM_PERF_COUNTERS; c++) begin
      pccr_n[c] = pccr_q[c];
      if (pccr_inc_q[c] && (!pcmr_q[PCMR_SAT] || (pccr_q[c] != '1))) begin
        pccr_n[c] = pccr_q[c] + XLEN'(1); // wraps when not saturating
      end
      // software write wins over the pending increment
      if (csr_we_i && is_pccr && (pccr_all_sel || (pccr_index == 5'(c)))) begin
        pccr_n[c] = csr_wdata_i;
      end
    end
  end

  always_comb begin
    pcer_n = pcer_q;
    pcmr_n = pcmr_q;
    if (csr_we_i && is_pcer) pcer_n = csr_wdata_i[NUM_PERF_COUNTERS-1:0];
    if (csr_we_i && is_pcmr) pcmr_n = csr_wdata_i[1:0];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pcer_q     <= '0;          // nothing counts out of reset
      pcmr_q     <= PCMR_RESET;
      pccr_inc_q <= '0;
      pccr_q     <= '0;
    end else begin
      pcer_q     <= pcer_n;
      pcmr_q     <= pcmr_n;
      pccr_inc_q <= pccr_inc;   // add lands one cycle later
      pccr_q     <= pccr_n;
    end
  end

endmodule

`default_nettype wire

//--- logic/machine_csrs.sv
`timescale 1ns/1ns
`default_nettype none

module machine_csrs import csr_pkg::*; #(
  parameter bit RV32E = 1'b0,
  parameter bit RV32M = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_ni,

  // register port, write data already merged
  input  csr_num_e        csr_addr_i,
  input  logic [XLEN-1:0] csr_wdata_i,
  input  logic            csr_we_i,

  // static configuration
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic [3:0]      core_id_i,
  input  logic [5:0]      cluster_id_i,

  // trap entry and return
  input  logic [XLEN-1:0] pc_if_i,
  input  logic [XLEN-1:0] pc_id_i,
  input  logic            csr_save_if_i,
  input  logic            csr_save_id_i,
  input  logic            csr_save_cause_i,
  input  logic [5:0]      csr_cause_i,       // [5] irq, [4:0] code
  input  logic            csr_restore_mret_i,

  output logic [XLEN-1:0] csr_rdata_o,
  output logic            m_irq_enable_o,
  output logic [XLEN-1:0] mepc_o
);

  // I and C always present while E and M follow the core config
  localparam logic [XLEN-1:0] MISA_VALUE =
      (XLEN'(1)     <<  2)   // C
    | (XLEN'(RV32E) <<  4)   // E
    | (XLEN'(1)     <<  8)   // I
    | (XLEN'(RV32M) << 12)   // M
    | (XLEN'(MXL_RV32) << 30);

  logic            mie_q, mie_n;     // global irq enable
  logic            mpie_q, mpie_n;   // enable before the last trap
  logic [XLEN-1:0] mepc_q, mepc_n;
  logic [5:0]      mcause_q, mcause_n;
  logic [XLEN-1:0] exception_pc;

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        csr_rdata_o[12:11]            = PRIV_LVL_M; // mpp pinned to machine
        csr_rdata_o[MSTATUS_MPIE_BIT] = mpie_q;
        csr_rdata_o[MSTATUS_MIE_BIT]  = mie_q;
      end
      CSR_MISA:    csr_rdata_o = MISA_VALUE;
      CSR_MTVEC:   csr_rdata_o = boot_addr_i;   // vector base fixed at boot
      CSR_MEPC:    csr_rdata_o = mepc_q;
      CSR_MCAUSE:  csr_rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      CSR_MHARTID: csr_rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default:     csr_rdata_o = '0;           // not ours
    endcase
  end

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  // saved pc comes from id unless only fetch asks for it
  assign exception_pc = (csr_save_if_i && !csr_save_id_i) ? pc_if_i : pc_id_i;

  always_comb begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;

    // software writes
    if (csr_we_i) begin
      case (csr_addr_i)
        CSR_MSTATUS: begin
          mie_n  = csr_wdata_i[MSTATUS_MIE_BIT];
          mpie_n = csr_wdata_i[MSTATUS_MPIE_BIT];
        end
        CSR_MEPC:   mepc_n   = csr_wdata_i;
        CSR_MCAUSE: mcause_n = {csr_wdata_i[XLEN-1], csr_wdata_i[4:0]};
        default: ;
      endcase
    end

    // trap entry beats any software write in the same cycle
    if (csr_save_cause_i) begin
      mepc_n   = exception_pc;
      mcause_n = csr_cause_i;
      mpie_n   = mie_q;  // stack the enable
      mie_n    = 1'b0;   // handler runs masked
    end else if (csr_restore_mret_i) begin
      mie_n  = mpie_q;   // pop
      mpie_n = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  assign m_irq_enable_o = mie_q;
  assign mepc_o         = mepc_q;

endmodule

`default_nettype wire

//--- logic/csr_access.sv
`timescale 1ns/1ns
`default_nettype none

module csr_access import csr_pkg::*; (
  // port from the core
  input  logic            csr_access_i,
  input  csr_op_e         csr_op_i,
  input  logic [XLEN-1:0] csr_wdata_i,

  // read sources
  input  logic [XLEN-1:0] machine_rdata_i,
  input  logic [XLEN-1:0] perf_rdata_i,
  input  logic            perf_hit_i,

  // merged read data and the write towards both register blocks
  output logic [XLEN-1:0] csr_rdata_o,
  output logic [XLEN-1:0] csr_wdata_o,
  output logic            csr_we_o
);

  ////////////////////////////////////////
  // read merge
  ////////////////////////////////////////

  // counters win when they claim the address
  // unknown addresses fall through to the machine block which returns zero
  assign csr_rdata_o = perf_hit_i ? perf_rdata_i : machine_rdata_i;

  ////////////////////////////////////////
  // read-modify-write
  ////////////////////////////////////////

  always_comb begin
    csr_wdata_o = csr_wdata_i;
    unique case (csr_op_i)
      CSR_OP_WRITE: csr_wdata_o = csr_wdata_i;                // plain write
      CSR_OP_SET:   csr_wdata_o = csr_wdata_i | csr_rdata_o;  // or in mask
      CSR_OP_CLEAR: csr_wdata_o = ~csr_wdata_i & csr_rdata_o; // knock out mask
      CSR_OP_NONE:  csr_wdata_o = csr_wdata_i;                // data unused
      default:      csr_wdata_o = csr_wdata_i;
    endcase
  end

  // single strobe test for the whole unit
  always_comb begin
    csr_we_o = 1'b0;
    if (csr_access_i) begin
      csr_we_o = (csr_op_i != CSR_OP_NONE); // read-only access does not write
    end
  end

endmodule

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////
  // widths and field constants
  ////////////////////////////////////////

  localparam int unsigned XLEN              = 32;
  localparam int unsigned NUM_PERF_COUNTERS = 9;

  localparam logic [1:0] MXL_RV32         = 2'd1;  // misa[31:30] for a 32-bit machine
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam logic [1:0] PRIV_LVL_M       = 2'd3;  // mpp always reads machine mode
  localparam logic [1:0] PCMR_RESET       = 2'd3;  // enable + saturate

  // upper address bits of the counter window 0x780..0x79F
  localparam logic [6:0] PCCR_BASE_UPPER = 7'b0111100;

  ////////////////////////////////////////
  // port opcodes and addresses
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MISA    = 12'h301,
    CSR_MTVEC   = 12'h305,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342,
    CSR_PCCR31  = 12'h79F,  // hits every counter at once
    CSR_PCER    = 12'h7A0,
    CSR_PCMR    = 12'h7A1,
    CSR_MHARTID = 12'hF14
  } csr_num_e;

  // counter slot of each event
  typedef enum int unsigned {
    EV_CYCLE        = 0,
    EV_INSTR        = 1,
    EV_IMISS        = 2,
    EV_LOAD         = 3,
    EV_STORE        = 4,
    EV_JUMP         = 5,
    EV_BRANCH       = 6,
    EV_BRANCH_TAKEN = 7,
    EV_COMPRESSED   = 8
  } perf_event_e;

endpackage

`default_nettype wire
